// File: gpuSetup_defs.svh
// --------------------
// GPU setup unit widths and limits
// Shared by the geometry package and the RTL blocks
// --------------------
`ifndef GPU_SETUP_DEFS_SVH
`define GPU_SETUP_DEFS_SVH

// Vertex and pixel coordinate, signed
`define GPU_COORD_W     12

// Drawing area register, unsigned
`define GPU_DA_W        10

// Vertex difference before narrowing
`define GPU_DELTA_W     13

// Edge function value, 12x12 signed product
`define GPU_EQU_W       23

// Bresenham error term
`define GPU_LINE_D_W    14

// Largest vertex spans the hardware accepts
`define GPU_MAX_SPAN_X  1023
`define GPU_MAX_SPAN_Y  511

`endif

// File: gpuGeomPkg.sv
// --------------------
// Geometry types
// Coordinates, draw area, deltas and edge values
// --------------------
`default_nettype none

`include "gpuSetup_defs.svh"

package gpuGeomPkg;

	// Screen space vertex or pixel position
	typedef logic signed [`GPU_COORD_W-1:0] coord_t;

	// Draw area bound as held in the GPU register
	typedef logic [`GPU_DA_W-1:0] drawArea_t;

	// Vertex difference, one bit wider than a coordinate
	typedef logic signed [`GPU_DELTA_W-1:0] delta_t;

	// Edge function result
	typedef logic signed [`GPU_EQU_W-1:0] equ_t;

	// Line error accumulator
	typedef logic signed [`GPU_LINE_D_W-1:0] lineErr_t;

endpackage

`default_nettype wire

// File: gpuCtrlPkg.sv
// --------------------
// Control types
// Line stepper states and pixel pair result flags
// --------------------
`default_nettype none

package gpuCtrlPkg;

	// Line walker FSM
	typedef enum logic [1:0] {
		LINE_IDLE = 2'd0, // No line in progress
		LINE_RUN  = 2'd1, // Walking, end not reached yet
		LINE_LAST = 2'd2  // Sitting on V1, one step left
	} lineState_t;

	// Pixel pair verdict, bit 0 even pixel, bit 1 odd pixel
	typedef logic [1:0] pixResult_t;

endpackage

`default_nettype wire

// File: triSetup.sv
// --------------------
// Triangle setup
// Bounding box, draw area clip, early reject and edge coefficients
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "gpuSetup_defs.svh"

module triSetup (
	input  wire                    i_clk,
	input  wire                    i_arstN,
	input  wire                    i_load,
	input  gpuGeomPkg::coord_t     i_x0,
	input  gpuGeomPkg::coord_t     i_y0,
	input  gpuGeomPkg::coord_t     i_x1,
	input  gpuGeomPkg::coord_t     i_y1,
	input  gpuGeomPkg::coord_t     i_x2,
	input  gpuGeomPkg::coord_t     i_y2,
	input  gpuGeomPkg::drawArea_t  i_daX0,
	input  gpuGeomPkg::drawArea_t  i_daY0,
	input  gpuGeomPkg::drawArea_t  i_daX1,
	input  gpuGeomPkg::drawArea_t  i_daY1,
	output logic                   o_valid,
	output gpuGeomPkg::coord_t     o_vx0,
	output gpuGeomPkg::coord_t     o_vy0,
	output gpuGeomPkg::coord_t     o_vx1,
	output gpuGeomPkg::coord_t     o_vy1,
	output gpuGeomPkg::coord_t     o_vx2,
	output gpuGeomPkg::coord_t     o_vy2,
	output gpuGeomPkg::coord_t     o_coefA0,
	output gpuGeomPkg::coord_t     o_coefB0,
	output gpuGeomPkg::coord_t     o_coefA1,
	output gpuGeomPkg::coord_t     o_coefB1,
	output gpuGeomPkg::coord_t     o_coefA2,
	output gpuGeomPkg::coord_t     o_coefB2,
	output logic                   o_bias0,
	output logic                   o_bias1,
	output logic                   o_bias2,
	output gpuGeomPkg::coord_t     o_minX,
	output gpuGeomPkg::coord_t     o_maxX,
	output gpuGeomPkg::coord_t     o_minY,
	output gpuGeomPkg::coord_t     o_maxY,
	output logic                   o_earlyReject
);

	// Top-left rule, A negative or A zero with B negative
	function automatic logic isTopLeft(gpuGeomPkg::coord_t a, gpuGeomPkg::coord_t b);
		return a[`GPU_COORD_W-1] | ((a == '0) & b[`GPU_COORD_W-1]);
	endfunction

	gpuGeomPkg::drawArea_t daX0R;
	gpuGeomPkg::drawArea_t daY0R;
	gpuGeomPkg::drawArea_t daX1R;
	gpuGeomPkg::drawArea_t daY1R;

	// --------------------
	// Primitive capture
	// --------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN)
			o_valid <= 1'b0;
		else if (i_load)
			o_valid <= 1'b1; // Stays up, values held until next load
	end

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			o_vx0 <= i_x0;
			o_vy0 <= i_y0;
			o_vx1 <= i_x1;
			o_vy1 <= i_y1;
			o_vx2 <= i_x2;
			o_vy2 <= i_y2;
			daX0R <= i_daX0;
			daY0R <= i_daY0;
			daX1R <= i_daX1;
			daY1R <= i_daY1;
		end
	end

	// Draw area as signed coordinates, zero extended
	gpuGeomPkg::coord_t daX0;
	gpuGeomPkg::coord_t daY0;
	gpuGeomPkg::coord_t daX1;
	gpuGeomPkg::coord_t daY1;
	assign daX0 = gpuGeomPkg::coord_t'(daX0R);
	assign daY0 = gpuGeomPkg::coord_t'(daY0R);
	assign daX1 = gpuGeomPkg::coord_t'(daX1R);
	assign daY1 = gpuGeomPkg::coord_t'(daY1R);

	// --------------------
	// Bounding box
	// --------------------
	gpuGeomPkg::coord_t minX01;
	gpuGeomPkg::coord_t maxX01;
	gpuGeomPkg::coord_t minY01;
	gpuGeomPkg::coord_t maxY01;
	gpuGeomPkg::coord_t minXTri;
	gpuGeomPkg::coord_t maxXTri;
	gpuGeomPkg::coord_t minYTri;
	gpuGeomPkg::coord_t maxYTri;

	assign minX01  = (o_vx1 < o_vx0) ? o_vx1 : o_vx0;
	assign maxX01  = (o_vx1 > o_vx0) ? o_vx1 : o_vx0;
	assign minY01  = (o_vy1 < o_vy0) ? o_vy1 : o_vy0;
	assign maxY01  = (o_vy1 > o_vy0) ? o_vy1 : o_vy0;
	assign minXTri = (o_vx2 < minX01) ? o_vx2 : minX01;
	assign maxXTri = (o_vx2 > maxX01) ? o_vx2 : maxX01;
	assign minYTri = (o_vy2 < minY01) ? o_vy2 : minY01;
	assign maxYTri = (o_vy2 > maxY01) ? o_vy2 : maxY01;

	// Intersection with draw area, bounds inclusive
	assign o_minX = (minXTri < daX0) ? daX0 : minXTri;
	assign o_maxX = (maxXTri > daX1) ? daX1 : maxXTri;
	assign o_minY = (minYTri < daY0) ? daY0 : minYTri;
	assign o_maxY = (maxYTri > daY1) ? daY1 : maxYTri;

	// --------------------
	// Deltas and reject
	// --------------------
	gpuGeomPkg::delta_t dX10;
	gpuGeomPkg::delta_t dY10;
	gpuGeomPkg::delta_t dX20;
	gpuGeomPkg::delta_t dY20;
	gpuGeomPkg::delta_t dX21;
	gpuGeomPkg::delta_t dY12;

	assign dX10 = o_vx1 - o_vx0;
	assign dY10 = o_vy1 - o_vy0;
	assign dX20 = o_vx2 - o_vx0;
	assign dY20 = o_vy2 - o_vy0;
	assign dX21 = o_vx2 - o_vx1;
	assign dY12 = o_vy1 - o_vy2;

	logic rejectSize;
	logic rejectArea;

	assign rejectSize = (dX10 > `GPU_MAX_SPAN_X) | (dX10 < -`GPU_MAX_SPAN_X)
		| (dX20 > `GPU_MAX_SPAN_X) | (dX20 < -`GPU_MAX_SPAN_X)
		| (dY10 > `GPU_MAX_SPAN_Y) | (dY10 < -`GPU_MAX_SPAN_Y)
		| (dY20 > `GPU_MAX_SPAN_Y) | (dY20 < -`GPU_MAX_SPAN_Y);

	// Left, above, right, below; X1 and Y1 are the last drawable pixels
	assign rejectArea = (maxXTri < daX0) | (maxYTri < daY0)
		| (minXTri > daX1) | (minYTri > daY1);

	assign o_earlyReject = rejectSize | rejectArea;

	// --------------------
	// Edge coefficients
	// --------------------
	// A is the Y difference (multiplies pixel X distance), B the X difference
	assign o_coefA0 = gpuGeomPkg::coord_t'(dY12);  // V1 to V2
	assign o_coefB0 = gpuGeomPkg::coord_t'(dX21);
	assign o_coefA1 = gpuGeomPkg::coord_t'(dY20);  // V2 to V0
	assign o_coefB1 = gpuGeomPkg::coord_t'(-dX20);
	assign o_coefA2 = gpuGeomPkg::coord_t'(-dY10); // V0 to V1
	assign o_coefB2 = gpuGeomPkg::coord_t'(dX10);

	assign o_bias0 = isTopLeft(o_coefA0, o_coefB0);
	assign o_bias1 = isTopLeft(o_coefA1, o_coefB1);
	assign o_bias2 = isTopLeft(o_coefA2, o_coefB2);

endmodule

`default_nettype wire

// File: edgeTester.sv
// --------------------
// Pixel pair edge test
// Evaluates three edge functions for an even/odd pair, one register stage
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "gpuSetup_defs.svh"

module edgeTester (
	input  wire                  i_clk,
	input  wire                  i_arstN,
	input  wire                  i_valid,
	input  gpuGeomPkg::coord_t   i_pixX,
	input  gpuGeomPkg::coord_t   i_pixY,
	input  gpuGeomPkg::coord_t   i_vx0,
	input  gpuGeomPkg::coord_t   i_vy0,
	input  gpuGeomPkg::coord_t   i_vx1,
	input  gpuGeomPkg::coord_t   i_vy1,
	input  gpuGeomPkg::coord_t   i_vx2,
	input  gpuGeomPkg::coord_t   i_vy2,
	input  gpuGeomPkg::coord_t   i_coefA0,
	input  gpuGeomPkg::coord_t   i_coefB0,
	input  gpuGeomPkg::coord_t   i_coefA1,
	input  gpuGeomPkg::coord_t   i_coefB1,
	input  gpuGeomPkg::coord_t   i_coefA2,
	input  gpuGeomPkg::coord_t   i_coefB2,
	input  wire                  i_bias0,
	input  wire                  i_bias1,
	input  wire                  i_bias2,
	input  gpuGeomPkg::coord_t   i_minX,
	input  gpuGeomPkg::coord_t   i_maxX,
	input  gpuGeomPkg::coord_t   i_minY,
	input  gpuGeomPkg::coord_t   i_maxY,
	output logic                 o_valid,
	output logic                 o_validL,
	output logic                 o_validR
);

	localparam int MSB = `GPU_EQU_W - 1;

	// Even and odd pixel of the pair
	gpuGeomPkg::coord_t lx;
	gpuGeomPkg::coord_t rx;
	assign lx = {i_pixX[`GPU_COORD_W-1:1], 1'b0};
	assign rx = {i_pixX[`GPU_COORD_W-1:1], 1'b1};

	// Per edge view: start vertex, coefficients, bias
	gpuGeomPkg::coord_t startX [3];
	gpuGeomPkg::coord_t startY [3];
	gpuGeomPkg::coord_t coefA  [3];
	gpuGeomPkg::coord_t coefB  [3];
	gpuGeomPkg::equ_t   biasV  [3];

	assign startX[0] = i_vx1; // Edge V1 to V2
	assign startY[0] = i_vy1;
	assign startX[1] = i_vx2; // Edge V2 to V0
	assign startY[1] = i_vy2;
	assign startX[2] = i_vx0; // Edge V0 to V1
	assign startY[2] = i_vy0;

	assign coefA[0] = i_coefA0;
	assign coefB[0] = i_coefB0;
	assign coefA[1] = i_coefA1;
	assign coefB[1] = i_coefB1;
	assign coefA[2] = i_coefA2;
	assign coefB[2] = i_coefB2;

	// -1 on top-left edges
	assign biasV[0] = {`GPU_EQU_W{i_bias0}};
	assign biasV[1] = {`GPU_EQU_W{i_bias1}};
	assign biasV[2] = {`GPU_EQU_W{i_bias2}};

	// --------------------
	// Edge functions
	// --------------------
	gpuGeomPkg::equ_t wL [3];
	gpuGeomPkg::equ_t wR [3];
	logic [2:0] negL;
	logic [2:0] negR;

	for (genvar e = 0; e < 3; e++) begin : gEdge
		gpuGeomPkg::delta_t dX;
		gpuGeomPkg::delta_t dY;

		assign dX    = lx - startX[e];     // Distance from edge start
		assign dY    = i_pixY - startY[e];
		assign wL[e] = coefA[e] * dX + coefB[e] * dY + biasV[e];
		assign wR[e] = wL[e] + coefA[e];   // One pixel right
		assign negL[e] = wL[e][MSB];
		assign negR[e] = wR[e][MSB];
	end

	// Either orientation: all non-negative or all negative
	logic insideTriL;
	logic insideTriR;
	assign insideTriL = (negL == 3'b000) | (negL == 3'b111);
	assign insideTriR = (negR == 3'b000) | (negR == 3'b111);

	// Clipped box, inclusive on all sides
	logic inBoxY;
	logic inBoxL;
	logic inBoxR;
	assign inBoxY = (i_pixY >= i_minY) & (i_pixY <= i_maxY);
	assign inBoxL = inBoxY & (lx >= i_minX) & (lx <= i_maxX);
	assign inBoxR = inBoxY & (rx >= i_minX) & (rx <= i_maxX);

	gpuCtrlPkg::pixResult_t resNext;
	gpuCtrlPkg::pixResult_t resR;
	assign resNext = {insideTriR & inBoxR, insideTriL & inBoxL};

	// --------------------
	// Output stage
	// --------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid; // Back to back queries allowed
	end

	always_ff @(posedge i_clk) begin
		resR <= resNext;
	end

	assign o_validL = resR[0];
	assign o_validR = resR[1];

endmodule

`default_nettype wire

// File: lineStepper.sv
// --------------------
// Line walker
// Bresenham error term stepping from V0 until V1, with step enable
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lineStepper (
	input  wire                 i_clk,
	input  wire                 i_arstN,
	input  wire                 i_start,
	input  wire                 i_step,
	input  gpuGeomPkg::coord_t  i_x0,
	input  gpuGeomPkg::coord_t  i_y0,
	input  gpuGeomPkg::coord_t  i_x1,
	input  gpuGeomPkg::coord_t  i_y1,
	output gpuGeomPkg::coord_t  o_x,
	output gpuGeomPkg::coord_t  o_y,
	output logic                o_busy,
	output logic                o_last
);

	// --------------------
	// Start setup
	// --------------------
	gpuGeomPkg::lineErr_t dx;
	gpuGeomPkg::lineErr_t dy;
	gpuGeomPkg::lineErr_t adx;
	gpuGeomPkg::lineErr_t ady;
	logic                 swapIn;

	assign dx     = i_x1 - i_x0;
	assign dy     = i_y1 - i_y0;
	assign adx    = dx[$bits(dx)-1] ? -dx : dx;
	assign ady    = dy[$bits(dy)-1] ? -dy : dy;
	assign swapIn = ady > adx; // Y is the major axis

	gpuCtrlPkg::lineState_t state;
	gpuGeomPkg::lineErr_t   majorR;
	gpuGeomPkg::lineErr_t   minorR;
	gpuGeomPkg::lineErr_t   errR;
	gpuGeomPkg::coord_t     x1R;
	gpuGeomPkg::coord_t     y1R;
	logic                   swapR;
	logic                   negXR;
	logic                   negYR;

	// --------------------
	// Step logic
	// --------------------
	logic                 change;
	logic                 moveX;
	logic                 moveY;
	gpuGeomPkg::lineErr_t errNext;
	gpuGeomPkg::coord_t   incX;
	gpuGeomPkg::coord_t   incY;
	gpuGeomPkg::coord_t   nextX;
	gpuGeomPkg::coord_t   nextY;

	assign change  = errR > majorR;    // Minor axis moves too
	assign errNext = errR + (minorR <<< 1)
		- (change ? (majorR <<< 1) : gpuGeomPkg::lineErr_t'(0));
	assign moveX   = !swapR | change;
	assign moveY   = swapR | change;
	assign incX    = !moveX ? gpuGeomPkg::coord_t'(0)
		: (negXR ? gpuGeomPkg::coord_t'(-1) : gpuGeomPkg::coord_t'(1));
	assign incY    = !moveY ? gpuGeomPkg::coord_t'(0)
		: (negYR ? gpuGeomPkg::coord_t'(-1) : gpuGeomPkg::coord_t'(1));
	assign nextX   = o_x + incX;
	assign nextY   = o_y + incY;

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN)
			state <= gpuCtrlPkg::LINE_IDLE;
		else if (i_start)
			state <= ((i_x0 == i_x1) && (i_y0 == i_y1)) ? gpuCtrlPkg::LINE_LAST
				: gpuCtrlPkg::LINE_RUN; // Single point line starts on its end
		else if (i_step) begin
			case (state)
				gpuCtrlPkg::LINE_RUN:
					if ((nextX == x1R) && (nextY == y1R))
						state <= gpuCtrlPkg::LINE_LAST;
				gpuCtrlPkg::LINE_LAST: state <= gpuCtrlPkg::LINE_IDLE; // Final step
				default:               state <= gpuCtrlPkg::LINE_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			o_x    <= i_x0;
			o_y    <= i_y0;
			x1R    <= i_x1;
			y1R    <= i_y1;
			swapR  <= swapIn;
			negXR  <= dx[$bits(dx)-1];
			negYR  <= dy[$bits(dy)-1];
			majorR <= swapIn ? ady : adx;
			minorR <= swapIn ? adx : ady;
			errR   <= ((swapIn ? adx : ady) <<< 1) + gpuGeomPkg::lineErr_t'(!swapIn);
		end else if (i_step && (state == gpuCtrlPkg::LINE_RUN)) begin
			o_x  <= nextX; // Held while step is low
			o_y  <= nextY;
			errR <= errNext;
		end
	end

	assign o_busy = state != gpuCtrlPkg::LINE_IDLE;
	assign o_last = state == gpuCtrlPkg::LINE_LAST;

endmodule

`default_nettype wire

// File: gpuSetupUnit.sv
// --------------------
// GPU setup unit top
// Triangle setup, pixel pair test and line walker
// --------------------
`timescale 1ns/1ps
`default_nettype none

module gpuSetupUnit (
	input  wire                    i_clk,
	input  wire                    i_arstN,
	input  gpuGeomPkg::coord_t     i_x0,
	input  gpuGeomPkg::coord_t     i_y0,
	input  gpuGeomPkg::coord_t     i_x1,
	input  gpuGeomPkg::coord_t     i_y1,
	input  gpuGeomPkg::coord_t     i_x2,
	input  gpuGeomPkg::coord_t     i_y2,
	input  gpuGeomPkg::drawArea_t  i_daX0,
	input  gpuGeomPkg::drawArea_t  i_daY0,
	input  gpuGeomPkg::drawArea_t  i_daX1,
	input  gpuGeomPkg::drawArea_t  i_daY1,
	input  wire                    i_loadPrim,
	input  wire                    i_pixValid,
	input  gpuGeomPkg::coord_t     i_pixX,
	input  gpuGeomPkg::coord_t     i_pixY,
	input  wire                    i_lineStart,
	input  wire                    i_lineStep,
	output logic                   o_setupValid,
	output logic                   o_earlyReject,
	output gpuGeomPkg::coord_t     o_minX,
	output gpuGeomPkg::coord_t     o_maxX,
	output gpuGeomPkg::coord_t     o_minY,
	output gpuGeomPkg::coord_t     o_maxY,
	output logic                   o_pixValid,
	output logic                   o_validL,
	output logic                   o_validR,
	output gpuGeomPkg::coord_t     o_lineX,
	output gpuGeomPkg::coord_t     o_lineY,
	output logic                   o_lineBusy,
	output logic                   o_lineLast
);

	// Registered vertices
	gpuGeomPkg::coord_t vx0;
	gpuGeomPkg::coord_t vy0;
	gpuGeomPkg::coord_t vx1;
	gpuGeomPkg::coord_t vy1;
	gpuGeomPkg::coord_t vx2;
	gpuGeomPkg::coord_t vy2;
	// Edge coefficients
	gpuGeomPkg::coord_t coefA0;
	gpuGeomPkg::coord_t coefB0;
	gpuGeomPkg::coord_t coefA1;
	gpuGeomPkg::coord_t coefB1;
	gpuGeomPkg::coord_t coefA2;
	gpuGeomPkg::coord_t coefB2;
	logic               bias0;
	logic               bias1;
	logic               bias2;

	// --------------------
	// Setup
	// --------------------
	triSetup u_triSetup (
		.i_clk(i_clk), .i_arstN(i_arstN), .i_load(i_loadPrim),
		.i_x0(i_x0), .i_y0(i_y0), .i_x1(i_x1), .i_y1(i_y1), .i_x2(i_x2), .i_y2(i_y2),
		.i_daX0(i_daX0), .i_daY0(i_daY0), .i_daX1(i_daX1), .i_daY1(i_daY1),
		.o_valid(o_setupValid),
		.o_vx0(vx0), .o_vy0(vy0), .o_vx1(vx1), .o_vy1(vy1), .o_vx2(vx2), .o_vy2(vy2),
		.o_coefA0(coefA0), .o_coefB0(coefB0),
		.o_coefA1(coefA1), .o_coefB1(coefB1),
		.o_coefA2(coefA2), .o_coefB2(coefB2),
		.o_bias0(bias0), .o_bias1(bias1), .o_bias2(bias2),
		.o_minX(o_minX), .o_maxX(o_maxX), .o_minY(o_minY), .o_maxY(o_maxY),
		.o_earlyReject(o_earlyReject)
	);

	// --------------------
	// Pixel pair test
	// --------------------
	edgeTester u_edgeTester (
		.i_clk(i_clk), .i_arstN(i_arstN),
		.i_valid(i_pixValid), .i_pixX(i_pixX), .i_pixY(i_pixY),
		.i_vx0(vx0), .i_vy0(vy0), .i_vx1(vx1), .i_vy1(vy1), .i_vx2(vx2), .i_vy2(vy2),
		.i_coefA0(coefA0), .i_coefB0(coefB0),
		.i_coefA1(coefA1), .i_coefB1(coefB1),
		.i_coefA2(coefA2), .i_coefB2(coefB2),
		.i_bias0(bias0), .i_bias1(bias1), .i_bias2(bias2),
		.i_minX(o_minX), .i_maxX(o_maxX), .i_minY(o_minY), .i_maxY(o_maxY),
		.o_valid(o_pixValid), .o_validL(o_validL), .o_validR(o_validR)
	);

	// Line endpoints come straight from the vertex inputs
	lineStepper u_lineStepper (
		.i_clk(i_clk), .i_arstN(i_arstN),
		.i_start(i_lineStart), .i_step(i_lineStep),
		.i_x0(i_x0), .i_y0(i_y0), .i_x1(i_x1), .i_y1(i_y1),
		.o_x(o_lineX), .o_y(o_lineY),
		.o_busy(o_lineBusy), .o_last(o_lineLast)
	);

endmodule

`default_nettype wire

// File: gpuSetupChecker.sv
// --------------------
// Setup unit checker
// Cycle model of setup, pixel pair test and line walk
// Compares every DUT response and counts errors
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "gpuSetup_defs.svh"

module gpuSetupChecker (
	input  wire                    i_clk,
	input  wire                    i_arstN,
	// Stimulus as the DUT sees it
	input  gpuGeomPkg::coord_t     i_x0,
	input  gpuGeomPkg::coord_t     i_y0,
	input  gpuGeomPkg::coord_t     i_x1,
	input  gpuGeomPkg::coord_t     i_y1,
	input  gpuGeomPkg::coord_t     i_x2,
	input  gpuGeomPkg::coord_t     i_y2,
	input  gpuGeomPkg::drawArea_t  i_daX0,
	input  gpuGeomPkg::drawArea_t  i_daY0,
	input  gpuGeomPkg::drawArea_t  i_daX1,
	input  gpuGeomPkg::drawArea_t  i_daY1,
	input  wire                    i_loadPrim,
	input  wire                    i_pixValid,
	input  gpuGeomPkg::coord_t     i_pixX,
	input  gpuGeomPkg::coord_t     i_pixY,
	input  wire                    i_lineStart,
	input  wire                    i_lineStep,
	input  wire                    i_tblReject, // Reject flag from the stimulus table
	// DUT responses
	input  wire                    i_setupValid,
	input  wire                    i_earlyReject,
	input  gpuGeomPkg::coord_t     i_minX,
	input  gpuGeomPkg::coord_t     i_maxX,
	input  gpuGeomPkg::coord_t     i_minY,
	input  gpuGeomPkg::coord_t     i_maxY,
	input  wire                    i_resPixValid,
	input  wire                    i_resValidL,
	input  wire                    i_resValidR,
	input  gpuGeomPkg::coord_t     i_lineX,
	input  gpuGeomPkg::coord_t     i_lineY,
	input  wire                    i_lineBusy,
	input  wire                    i_lineLast,
	output int                     o_errors,
	output int                     o_checks
);

	// Setup model
	bit setValid;
	bit expReject;
	int vx [3];
	int vy [3];
	int daX0;
	int daY0;
	int daX1;
	int daY1;
	int boxMinX;
	int boxMaxX;
	int boxMinY;
	int boxMaxY;
	// One stage pixel pipe
	bit pixPend;
	bit expL;
	bit expR;
	// Line model with position index along the major axis
	bit lnBusy;
	int lnIdx;
	int lnX0;
	int lnY0;
	int lnMaj;
	int lnMin;
	int lnSx;
	int lnSy;
	int lnTieUp; // 1 on X-major lines

	initial begin
		o_errors = 0;
		o_checks = 0;
	end

	function automatic int min3(int a, int b, int c);
		int m;
		m = (a < b) ? a : b;
		return (c < m) ? c : m;
	endfunction

	function automatic int max3(int a, int b, int c);
		int m;
		m = (a > b) ? a : b;
		return (c > m) ? c : m;
	endfunction

	function automatic int absVal(int v);
		return (v < 0) ? -v : v;
	endfunction

	// --------------------
	// Reference rules
	// --------------------
	function automatic bit rejectRule();
		bit area;
		bit span;
		area = (max3(vx[0], vx[1], vx[2]) < daX0) || (max3(vy[0], vy[1], vy[2]) < daY0)
			|| (min3(vx[0], vx[1], vx[2]) > daX1) || (min3(vy[0], vy[1], vy[2]) > daY1);
		span = (absVal(vx[1] - vx[0]) > `GPU_MAX_SPAN_X)
			|| (absVal(vx[2] - vx[0]) > `GPU_MAX_SPAN_X)
			|| (absVal(vy[1] - vy[0]) > `GPU_MAX_SPAN_Y)
			|| (absVal(vy[2] - vy[0]) > `GPU_MAX_SPAN_Y);
		return area || span;
	endfunction

	// Edge from S to E where top-left edges lose their zero
	function automatic int edgeValue(int sx, int sy, int ex, int ey, int px, int py);
		int a;
		int b;
		int bias;
		a    = sy - ey;
		b    = ex - sx;
		bias = ((a < 0) || ((a == 0) && (b < 0))) ? 1 : 0;
		return a * (px - sx) + b * (py - sy) - bias;
	endfunction

	function automatic bit pixelInside(int px, int py);
		int  w0;
		int  w1;
		int  w2;
		bit  inTri;
		bit  box;
		w0    = edgeValue(vx[1], vy[1], vx[2], vy[2], px, py); // V1 to V2
		w1    = edgeValue(vx[2], vy[2], vx[0], vy[0], px, py); // V2 to V0
		w2    = edgeValue(vx[0], vy[0], vx[1], vy[1], px, py); // V0 to V1
		inTri = ((w0 >= 0) && (w1 >= 0) && (w2 >= 0)) || ((w0 < 0) && (w1 < 0) && (w2 < 0));
		box   = (px >= boxMinX) && (px <= boxMaxX) && (py >= boxMinY) && (py <= boxMaxY);
		return inTri && box;
	endfunction

	// Point i of the walk with the minor axis rounded to nearest
	// Ties round up on X-major lines, down on Y-major ones
	function automatic int lineCoord(int i, bit wantY);
		int minorPos;
		minorPos = (lnMaj == 0) ? 0 : (2 * i * lnMin + lnMaj - 1 + lnTieUp) / (2 * lnMaj);
		if (lnTieUp == 1)
			return wantY ? lnY0 + lnSy * minorPos : lnX0 + lnSx * i;
		return wantY ? lnY0 + lnSy * i : lnX0 + lnSx * minorPos;
	endfunction

	// --------------------
	// Compare helpers
	// --------------------
	task automatic compareBit(input string name, input logic expV, input logic gotV);
		o_checks++;
		if (gotV !== expV) begin
			o_errors++;
			$display("ERR %s exp=%h got=%h at %0t", name, expV, gotV, $time);
		end
	endtask

	task automatic compareCoord(input string name, input gpuGeomPkg::coord_t expV,
		input gpuGeomPkg::coord_t gotV);
		o_checks++;
		if (gotV !== expV) begin
			o_errors++;
			$display("ERR %s exp=%h got=%h at %0t", name, expV, gotV, $time);
		end
	endtask

	task automatic checkResponses();
		compareBit("o_setupValid", setValid, i_setupValid);
		if (setValid) begin
			compareCoord("o_minX", gpuGeomPkg::coord_t'(boxMinX), i_minX);
			compareCoord("o_maxX", gpuGeomPkg::coord_t'(boxMaxX), i_maxX);
			compareCoord("o_minY", gpuGeomPkg::coord_t'(boxMinY), i_minY);
			compareCoord("o_maxY", gpuGeomPkg::coord_t'(boxMaxY), i_maxY);
			compareBit("o_earlyReject", expReject, i_earlyReject);
		end
		compareBit("o_pixValid", pixPend, i_resPixValid);
		if (pixPend) begin
			compareBit("o_validL", expL, i_resValidL);
			compareBit("o_validR", expR, i_resValidR);
		end
		compareBit("o_lineBusy", lnBusy, i_lineBusy);
		compareBit("o_lineLast", lnBusy && (lnIdx == lnMaj), i_lineLast);
		if (lnBusy) begin
			compareCoord("o_lineX", gpuGeomPkg::coord_t'(lineCoord(lnIdx, 1'b0)), i_lineX);
			compareCoord("o_lineY", gpuGeomPkg::coord_t'(lineCoord(lnIdx, 1'b1)), i_lineY);
		end
	endtask

	task automatic captureSetup();
		vx[0] = int'(i_x0);
		vy[0] = int'(i_y0);
		vx[1] = int'(i_x1);
		vy[1] = int'(i_y1);
		vx[2] = int'(i_x2);
		vy[2] = int'(i_y2);
		daX0  = int'(i_daX0);
		daY0  = int'(i_daY0);
		daX1  = int'(i_daX1);
		daY1  = int'(i_daY1);
		// Vertex box limited to the drawing area
		boxMinX = min3(vx[0], vx[1], vx[2]);
		boxMaxX = max3(vx[0], vx[1], vx[2]);
		boxMinY = min3(vy[0], vy[1], vy[2]);
		boxMaxY = max3(vy[0], vy[1], vy[2]);
		if (boxMinX < daX0)
			boxMinX = daX0;
		if (boxMaxX > daX1)
			boxMaxX = daX1;
		if (boxMinY < daY0)
			boxMinY = daY0;
		if (boxMaxY > daY1)
			boxMaxY = daY1;
		expReject = rejectRule();
		setValid  = 1'b1;
		if (expReject != i_tblReject) begin
			o_errors++;
			$display("Stimulus table reject flag %0d disagrees with the reject rules",
				i_tblReject);
		end
	endtask

	task automatic advanceModel();
		int lx;
		int dx;
		int dy;
		// Query sees the setup from before a load in the same cycle
		pixPend = i_pixValid;
		if (i_pixValid) begin
			lx   = int'(i_pixX) & ~1; // Even pixel
			expL = pixelInside(lx, int'(i_pixY));
			expR = pixelInside(lx + 1, int'(i_pixY));
		end
		if (i_lineStart) begin
			lnX0    = int'(i_x0);
			lnY0    = int'(i_y0);
			dx      = int'(i_x1) - lnX0;
			dy      = int'(i_y1) - lnY0;
			lnTieUp = (absVal(dx) >= absVal(dy)) ? 1 : 0;
			lnMaj   = (lnTieUp == 1) ? absVal(dx) : absVal(dy);
			lnMin   = (lnTieUp == 1) ? absVal(dy) : absVal(dx);
			lnSx    = (dx < 0) ? -1 : 1;
			lnSy    = (dy < 0) ? -1 : 1;
			lnIdx   = 0;
			lnBusy  = 1'b1;
		end else if (i_lineStep && lnBusy) begin
			if (lnIdx == lnMaj)
				lnBusy = 1'b0; // Final step off V1
			else
				lnIdx++;
		end
		if (i_loadPrim)
			captureSetup();
	endtask

	// --------------------
	// Per cycle compare followed by model advance
	// --------------------
	always @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			setValid = 1'b0;
			pixPend  = 1'b0;
			lnBusy   = 1'b0;
		end else begin
			checkResponses();
			advanceModel();
		end
	end

endmodule

`default_nettype wire

// File: tb_gpuSetupUnit.sv
// --------------------
// GPU setup unit testbench
// Triangle and line tables applied in a loop, checker does the comparing
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_gpuSetupUnit;

	localparam int NUM_TRI  = 12;
	localparam int NUM_LINE = 14;
	localparam int NUM_RAND = 8;   // Random pairs per triangle
	localparam int WAIT_MAX = 200; // Cycles before a wait gives up

	logic clk = 1'b0;
	logic arstN;
	gpuGeomPkg::coord_t    x0, y0, x1, y1, x2, y2;
	gpuGeomPkg::drawArea_t daX0, daY0, daX1, daY1;
	logic loadPrim, pixValid, lineStart, lineStep, tblReject;
	gpuGeomPkg::coord_t    pixX, pixY;
	logic setupValid, earlyReject, resPixValid, validL, validR, lineBusy, lineLast;
	gpuGeomPkg::coord_t    minX, maxX, minY, maxY, lineX, lineY;
	int errCount;
	int checkCount;
	int timeoutCount = 0;
	int seed;

	// x0 y0 x1 y1 x2 y2 daX0 daY0 daX1 daY1 reject
	int triTbl [NUM_TRI][11] = '{
		'{ 10,  10,   40,  12,  20,  35,  0,  0,   63,  63, 0}, // Clockwise
		'{ 10,  10,   20,  35,  40,  12,  0,  0,   63,  63, 0}, // Counter clockwise
		'{  8,   8,   24,   8,   8,  24,  0,  0,   63,  63, 0}, // Axis edges, on-edge pixels
		'{  8,   8,    8,  24,  24,   8,  0,  0,   63,  63, 0}, // Same, other winding
		'{-20, -10,   50,   5,  10,  60,  5,  5,   30,  40, 0}, // Clipped on all sides
		'{  0,  10,   20,  10,  10,  30, 21,  0,  100, 100, 1}, // Left of area
		'{ 10,   0,   30,   0,  20,  19,  0, 20,  100, 100, 1}, // Above
		'{101,  10,  120,  10, 110,  30,  0,  0,  100, 100, 1}, // Right
		'{ 10, 101,   30, 110,  20, 120,  0,  0,  100, 100, 1}, // Below
		'{  0,   0, 1024,   0,   0,  10,  0,  0, 1023, 511, 1}, // X span 1024
		'{  0,   0,   10, 512,   0,  10,  0,  0, 1023, 511, 1}, // Y span 512
		'{  0,   0, 1023,   5,   0,  10,  0,  0, 1023, 511, 0}  // Widest accepted
	};

	// x0 y0 x1 y1, eight octants first
	int lineTbl [NUM_LINE][4] = '{
		'{10, 10, 17, 13}, '{10, 10, 13, 17}, '{10, 10,  7, 17}, '{10, 10,  3, 13},
		'{10, 10,  3,  7}, '{10, 10,  7,  3}, '{10, 10, 13,  3}, '{10, 10, 17,  7},
		'{-4,  6, -4,  6}, // Single point
		'{ 0,  0,  6,  6}, '{30, -2, 20, -2}, '{ 5,  9,  5,  1},
		'{ 0,  0,  4,  2}, '{ 0,  0, -2, -4}  // Rounding ties
	};

	always #4 clk = ~clk;

	gpuSetupUnit u_dut (
		.i_clk(clk), .i_arstN(arstN),
		.i_x0(x0), .i_y0(y0), .i_x1(x1), .i_y1(y1), .i_x2(x2), .i_y2(y2),
		.i_daX0(daX0), .i_daY0(daY0), .i_daX1(daX1), .i_daY1(daY1),
		.i_loadPrim(loadPrim), .i_pixValid(pixValid), .i_pixX(pixX), .i_pixY(pixY),
		.i_lineStart(lineStart), .i_lineStep(lineStep),
		.o_setupValid(setupValid), .o_earlyReject(earlyReject),
		.o_minX(minX), .o_maxX(maxX), .o_minY(minY), .o_maxY(maxY),
		.o_pixValid(resPixValid), .o_validL(validL), .o_validR(validR),
		.o_lineX(lineX), .o_lineY(lineY), .o_lineBusy(lineBusy), .o_lineLast(lineLast)
	);

	gpuSetupChecker u_checker (
		.i_clk(clk), .i_arstN(arstN),
		.i_x0(x0), .i_y0(y0), .i_x1(x1), .i_y1(y1), .i_x2(x2), .i_y2(y2),
		.i_daX0(daX0), .i_daY0(daY0), .i_daX1(daX1), .i_daY1(daY1),
		.i_loadPrim(loadPrim), .i_pixValid(pixValid), .i_pixX(pixX), .i_pixY(pixY),
		.i_lineStart(lineStart), .i_lineStep(lineStep), .i_tblReject(tblReject),
		.i_setupValid(setupValid), .i_earlyReject(earlyReject),
		.i_minX(minX), .i_maxX(maxX), .i_minY(minY), .i_maxY(maxY),
		.i_resPixValid(resPixValid), .i_resValidL(validL), .i_resValidR(validR),
		.i_lineX(lineX), .i_lineY(lineY), .i_lineBusy(lineBusy), .i_lineLast(lineLast),
		.o_errors(errCount), .o_checks(checkCount)
	);

	function automatic int min3(int a, int b, int c);
		int m;
		m = (a < b) ? a : b;
		return (c < m) ? c : m;
	endfunction

	function automatic int max3(int a, int b, int c);
		int m;
		m = (a > b) ? a : b;
		return (c > m) ? c : m;
	endfunction

	// --------------------
	// Triangle stimulus
	// --------------------
	task automatic loadTriangle(input int row);
		int guard;
		bit done;
		@(posedge clk);
		x0 <= gpuGeomPkg::coord_t'(triTbl[row][0]);
		y0 <= gpuGeomPkg::coord_t'(triTbl[row][1]);
		x1 <= gpuGeomPkg::coord_t'(triTbl[row][2]);
		y1 <= gpuGeomPkg::coord_t'(triTbl[row][3]);
		x2 <= gpuGeomPkg::coord_t'(triTbl[row][4]);
		y2 <= gpuGeomPkg::coord_t'(triTbl[row][5]);
		daX0 <= gpuGeomPkg::drawArea_t'(triTbl[row][6]);
		daY0 <= gpuGeomPkg::drawArea_t'(triTbl[row][7]);
		daX1 <= gpuGeomPkg::drawArea_t'(triTbl[row][8]);
		daY1 <= gpuGeomPkg::drawArea_t'(triTbl[row][9]);
		tblReject <= (triTbl[row][10] != 0);
		loadPrim  <= 1'b1;
		@(posedge clk);
		loadPrim <= 1'b0;
		guard = 0;
		done  = 1'b0;
		while (!done && (guard < WAIT_MAX)) begin
			@(posedge clk);
			done = (setupValid === 1'b1);
			guard++;
		end
		if (!done) begin
			timeoutCount++;
			$display("Timeout waiting for setup valid on triangle %0d", row);
		end
	endtask

	// One pair per call, calls back to back give consecutive queries
	task automatic queryPixel(input int px, input int py);
		@(posedge clk);
		pixValid <= 1'b1;
		pixX     <= gpuGeomPkg::coord_t'(px);
		pixY     <= gpuGeomPkg::coord_t'(py);
	endtask

	task automatic pixelBatch(input int row);
		int bxMin;
		int bxMax;
		int byMin;
		int byMax;
		int k;
		int r;
		int c;
		bxMin = min3(triTbl[row][0], triTbl[row][2], triTbl[row][4]);
		bxMax = max3(triTbl[row][0], triTbl[row][2], triTbl[row][4]);
		byMin = min3(triTbl[row][1], triTbl[row][3], triTbl[row][5]);
		byMax = max3(triTbl[row][1], triTbl[row][3], triTbl[row][5]);
		for (k = 0; k < 3; k++) begin
			queryPixel(triTbl[row][2*k], triTbl[row][2*k+1]); // Vertex
			c = (k + 1) % 3;
			queryPixel((triTbl[row][2*k] + triTbl[row][2*c]) / 2,
				(triTbl[row][2*k+1] + triTbl[row][2*c+1]) / 2); // Edge midpoint
		end
		queryPixel(bxMin, byMin);
		queryPixel(bxMax, byMax);
		queryPixel(bxMin - 2, byMin);     // Outside the box
		queryPixel(bxMax + 3, byMax + 1);
		for (k = 0; k < NUM_RAND; k++) begin
			r = $unsigned($random(seed)) % (bxMax - bxMin + 1);
			c = $unsigned($random(seed)) % (byMax - byMin + 1);
			queryPixel(bxMin + r, byMin + c);
		end
		@(posedge clk);
		pixValid <= 1'b0;
	endtask

	// --------------------
	// Line stimulus
	// --------------------
	task automatic walkLine(input int row, input bit stall);
		int guard;
		bit done;
		@(posedge clk);
		x0 <= gpuGeomPkg::coord_t'(lineTbl[row][0]);
		y0 <= gpuGeomPkg::coord_t'(lineTbl[row][1]);
		x1 <= gpuGeomPkg::coord_t'(lineTbl[row][2]);
		y1 <= gpuGeomPkg::coord_t'(lineTbl[row][3]);
		lineStart <= 1'b1;
		@(posedge clk);
		lineStart <= 1'b0;
		lineStep  <= stall ? ($random(seed) & 1) : 1'b1;
		guard = 0;
		done  = 1'b0;
		while (!done && (guard < WAIT_MAX)) begin
			@(posedge clk);
			if (lineBusy === 1'b0)
				done = 1'b1;
			else
				lineStep <= stall ? ($random(seed) & 1) : 1'b1; // Random holds
			guard++;
		end
		lineStep <= 1'b0;
		if (!done) begin
			timeoutCount++;
			$display("Timeout waiting for line %0d to finish", row);
		end
	endtask

	initial begin
		int t;
		seed      = 32'h21ba1827;
		arstN     = 1'b0;
		{x0, y0, x1, y1, x2, y2} = '0;
		{daX0, daY0, daX1, daY1} = '0;
		{pixX, pixY} = '0;
		loadPrim  = 1'b0;
		pixValid  = 1'b0;
		lineStart = 1'b0;
		lineStep  = 1'b0;
		tblReject = 1'b0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		repeat (2) @(posedge clk);
		for (t = 0; t < NUM_TRI; t++) begin
			loadTriangle(t);
			pixelBatch(t);
		end
		for (t = 0; t < NUM_LINE; t++) begin
			walkLine(t, 1'b0); // Full speed
			walkLine(t, 1'b1); // With back-pressure
		end
		repeat (4) @(posedge clk);
		$display("Checks %0d, errors %0d, timeouts %0d", checkCount, errCount, timeoutCount);
		if ((errCount == 0) && (timeoutCount == 0))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
gpuGeomPkg.sv
gpuCtrlPkg.sv
triSetup.sv
edgeTester.sv
lineStepper.sv
gpuSetupUnit.sv
gpuSetupChecker.sv
tb_gpuSetupUnit.sv
